//--- flist.f
+incdir+.
cpu_pkg.sv
stage_sequencer.sv
program_counter.sv
instr_decoder.sv
register_file.sv
execute_stage.sv
cpu_core.sv
tb_cpu_core.sv

//--- run.sh
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_cpu_core -o sim_cpu_core
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_cpu_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0

//--- tb_cpu_core.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu_core;
    import cpu_pkg::*;

    localparam int ROM_DEPTH = 256;
    localparam int MEM_DEPTH = 256;

    logic             clk;
    logic             rst;
    instr_t           instr_in;
    logic [`XLEN-1:0] pc;
    dmem_req_t        dmem_req;
    dmem_rsp_t        dmem_rsp = '0;

    logic [15:0] rom [ROM_DEPTH];
    logic [15:0] dmem [MEM_DEPTH];
    logic [15:0] ref_mem [MEM_DEPTH];
    logic [15:0] ref_regs [8];
    int          delays [256];
    logic [31:0] lfsr;

    int prog_len = 0;
    int limit = 0;
    int cycles = 0;
    int errors = 0;
    int boot_errors = 0;
    int timeouts = 0;
    int req_count = 0;
    int halt_wait = 0;
    int wait_cnt;

    logic        done = 1'b0;
    logic        pending;
    logic [7:0]  load_addr;
    logic [15:0] last_pc;
    logic [15:0] next_pc_exp;
    logic        req_seen;
    logic        exp_access;
    logic        exp_store;
    logic [15:0] exp_addr;
    logic [15:0] exp_wdata;

    cpu_core dut (
        .clk      (clk),
        .rst      (rst),
        .instr_in (instr_in),
        .pc       (pc),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp)
    );

    // Instruction ROM answers combinationally
    assign instr_in = rom[pc[7:0]];

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic next_random_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic int random_field(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = v * 2 + (next_random_bit() ? 1 : 0);
        end
        return v;
    endfunction

    // Memory decodes the low 8 address bits
    function automatic logic [15:0] fill_word(input int i);
        return {i[7:0], i[7:0] ^ 8'ha5} ^ 16'h1e5c;
    endfunction

    task automatic emit_word(input int cls, input int op, input int dst, input int rs1,
                             input int low);
        rom[prog_len] = {cls[1:0], op[2:0], dst[2:0], rs1[2:0], low[4:0]};
        prog_len++;
    endtask

    task automatic alu_reg(input int op, input int dst, input int rs1, input int rs2);
        emit_word(0, op, dst, rs1, rs2 * 4);
    endtask

    task automatic alu_imm(input int op, input int dst, input int rs1, input int imm);
        emit_word(1, op, dst, rs1, imm);
    endtask

    task automatic store_word(input int src, input int base, input int off);
        emit_word(2, 1, src, base, off);
    endtask

    task automatic load_word(input int dst, input int base, input int off);
        emit_word(2, 0, dst, base, off);
    endtask

    task automatic jump_if(input int cond, input int test, input int tgt);
        emit_word(3, cond, 0, test, tgt * 4);
    endtask

    // Loads a value up to 255 in three instructions
    task automatic load_const(input int rd, input int value);
        alu_imm(0, rd, 0, value / 16);
        alu_imm(5, rd, rd, 4);
        alu_imm(0, rd, rd, value % 16);
    endtask

    task automatic build_program();
        int base;
        int conds [5];
        conds = '{0, 1, 2, 3, 5};
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = 16'h0000;
        end
        // Both ALU forms for every op with results stored at r6 plus offset
        for (int round = 0; round < 2; round++) begin
            load_const(6, 64 + 16 * round);
            alu_imm(0, 1, 0, random_field(5));
            alu_imm(5, 1, 1, 6);
            alu_imm(0, 1, 1, random_field(5));
            alu_imm(0, 2, 0, random_field(5));
            alu_imm(5, 2, 2, 4);
            alu_imm(0, 2, 2, random_field(5));
            for (int op = 0; op < 8; op++) begin
                alu_reg(op, 3, 1, 2);
                store_word(3, 6, 2 * op);
                alu_imm(op, 4, 1, random_field(5));
                store_word(4, 6, 2 * op + 1);
            end
        end
        // Loads shown by later stores
        // Offset 29 is -3 and reaches an untouched word
        load_word(5, 6, 3);
        store_word(5, 0, 7);
        load_word(4, 0, 7);
        store_word(4, 0, 8);
        load_word(5, 0, 29);
        store_word(5, 0, 9);
        // Tested values zero, positive and negative
        alu_imm(0, 1, 0, 5);
        alu_imm(0, 2, 0, 29);
        for (int c = 0; c < 5; c++) begin
            for (int t = 0; t < 3; t++) begin
                base = prog_len;
                load_const(7, base + 5);
                jump_if(conds[c], t, 7);
                alu_imm(0, 3, 3, 1);
            end
        end
        store_word(3, 0, 10);
        base = prog_len;
        load_const(7, base + 3);
        jump_if(0, 0, 7);
    endtask

    // Executes one instruction on the model state and returns the next pc
    function automatic logic [15:0] ref_step(input logic [15:0] w, input logic [15:0] cur);
        logic [1:0]  cls;
        logic [2:0]  op;
        logic [2:0]  dst;
        logic [2:0]  rs1;
        logic [2:0]  rs2;
        logic [15:0] imm;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] r;
        logic [15:0] nxt;
        logic        taken;
        cls = w[15:14];
        op  = w[13:11];
        dst = w[10:8];
        rs1 = w[7:5];
        rs2 = w[4:2];
        imm = {{11{w[4]}}, w[4:0]};
        a   = ref_regs[rs1];
        nxt = cur + 16'd1;
        exp_access = 1'b0;
        exp_store  = 1'b0;
        exp_addr   = '0;
        exp_wdata  = '0;
        case (cls)
            2'b00, 2'b01: begin
                b = (cls == 2'b01) ? imm : ref_regs[rs2];
                case (op)
                    3'd0: r = a + b;
                    3'd1: r = a - b;
                    3'd2: r = a & b;
                    3'd3: r = a | b;
                    3'd4: r = a ^ b;
                    3'd5: r = a << b[3:0];
                    3'd6: r = a >> b[3:0];
                    default: r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
                endcase
                ref_regs[dst] = r;
            end
            2'b10: begin
                r = a + imm;
                if (op == 3'd0) begin
                    exp_access    = 1'b1;
                    exp_addr      = r;
                    ref_regs[dst] = ref_mem[r[7:0]];
                end else if (op == 3'd1) begin
                    exp_access       = 1'b1;
                    exp_store        = 1'b1;
                    exp_addr         = r;
                    exp_wdata        = ref_regs[dst];
                    ref_mem[r[7:0]]  = ref_regs[dst];
                end
            end
            default: begin
                case (op)
                    3'd0: taken = 1'b1;
                    3'd1: taken = (a == 16'd0);
                    3'd2: taken = (a != 16'd0);
                    3'd3: taken = a[15];
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    nxt = ref_regs[rs2];
                end
            end
        endcase
        return nxt;
    endfunction

    // Data memory model with one credit returned after a drawn delay
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                dmem[i] = fill_word(i);
            end
            pending  <= 1'b0;
            wait_cnt <= 0;
            dmem_rsp <= '0;
        end else begin
            dmem_rsp.credit <= 1'b0;
            if (dmem_req.valid && !pending) begin
                pending   <= 1'b1;
                wait_cnt  <= delays[req_count % 256];
                load_addr <= dmem_req.addr[7:0];
                if (dmem_req.store) begin
                    dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
                end
                req_count++;
            end else if (pending) begin
                if (wait_cnt <= 1) begin
                    dmem_rsp.credit <= 1'b1;
                    dmem_rsp.rdata  <= dmem[load_addr];
                    pending         <= 1'b0;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

    // Compares requests and pc against the reference
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                ref_regs[i] = '0;
            end
            for (int i = 0; i < MEM_DEPTH; i++) begin
                ref_mem[i] = fill_word(i);
            end
            last_pc     = '0;
            req_seen    = 1'b0;
            halt_wait   = 0;
            next_pc_exp = ref_step(rom[0], 16'd0);
        end else begin
            if (dmem_req.valid) begin
                if (pending) begin
                    $display("Data request issued while an earlier one is outstanding");
                    errors++;
                end
                if (!exp_access || req_seen) begin
                    $display("Unexpected data request for the instruction at pc %h", last_pc);
                    errors++;
                end else begin
                    if (dmem_req.store !== exp_store) begin
                        $display("MISMATCH dmem_req.store: got %h, expected %h",
                                 dmem_req.store, exp_store);
                        errors++;
                    end
                    if (dmem_req.addr !== exp_addr) begin
                        $display("MISMATCH dmem_req.addr: got %h, expected %h",
                                 dmem_req.addr, exp_addr);
                        errors++;
                    end
                    if (exp_store && dmem_req.wdata !== exp_wdata) begin
                        $display("MISMATCH dmem_req.wdata: got %h, expected %h",
                                 dmem_req.wdata, exp_wdata);
                        errors++;
                    end
                end
                req_seen = 1'b1;
            end
            if (pc != last_pc) begin
                if (exp_access && !req_seen) begin
                    $display("Memory instruction at pc %h finished without a request", last_pc);
                    errors++;
                end
                if (pc !== next_pc_exp) begin
                    $display("MISMATCH pc: got %h, expected %h", pc, next_pc_exp);
                    errors++;
                end
                last_pc     = pc;
                req_seen    = 1'b0;
                halt_wait   = 0;
                next_pc_exp = ref_step(rom[pc[7:0]], pc);
            end else if (next_pc_exp == last_pc) begin
                // Self-jump reached so let it run a few passes
                halt_wait++;
                if (halt_wait == 12) begin
                    done <= 1'b1;
                end
            end
        end
    end

    initial begin
        rst <= 1'b1;
        lfsr = 32'hd710_fba4;
        build_program();
        for (int i = 0; i < 256; i++) begin
            delays[i] = 1 + random_field(2);
        end
        limit = prog_len * 10 + 100;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (pc !== '0) begin
            $display("MISMATCH pc: got %h, expected %h", pc, 16'h0000);
            boot_errors++;
        end
        if (dmem_req.valid !== 1'b0) begin
            $display("Data request raised straight after reset");
            boot_errors++;
        end
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timeout: the final self-jump was not reached in %0d cycles", limit);
            timeouts++;
        end
        $display("Summary: %0d check errors, %0d reset errors, %0d timeouts, %0d requests",
                 errors, boot_errors, timeouts, req_count);
        if (errors + boot_errors + timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- cpu_core.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_core (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::instr_t    instr_in,
    output logic [`XLEN-1:0]   pc,
    output cpu_pkg::dmem_req_t dmem_req,
    input  cpu_pkg::dmem_rsp_t dmem_rsp
);
    import cpu_pkg::*;

    ctrl_t ctrl;

    // Stage strobes
    logic fetch_en;
    logic operand_en;
    logic result_en;
    logic load_en;
    logic rf_write;
    logic pc_update;
    logic dmem_valid;

    logic [`XLEN-1:0] rd_a;
    logic [`XLEN-1:0] rd_b;
    logic [`XLEN-1:0] wb_data;
    logic             jump_taken;
    logic [`XLEN-1:0] jump_target;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;

    stage_sequencer u_stage_sequencer (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (ctrl),
        .dmem_credit (dmem_rsp.credit),
        .dmem_valid  (dmem_valid),
        .fetch_en    (fetch_en),
        .operand_en  (operand_en),
        .result_en   (result_en),
        .load_en     (load_en),
        .rf_write    (rf_write),
        .pc_update   (pc_update)
    );

    program_counter u_program_counter (
        .clk         (clk),
        .rst         (rst),
        .pc_update   (pc_update),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .pc          (pc)
    );

    instr_decoder u_instr_decoder (
        .clk      (clk),
        .rst      (rst),
        .fetch_en (fetch_en),
        .instr_in (instr_in),
        .ctrl     (ctrl)
    );

    register_file u_register_file (
        .clk      (clk),
        .rst      (rst),
        .rf_write (rf_write),
        .ctrl     (ctrl),
        .wb_data  (wb_data),
        .rd_a     (rd_a),
        .rd_b     (rd_b)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .rst         (rst),
        .operand_en  (operand_en),
        .result_en   (result_en),
        .load_en     (load_en),
        .ctrl        (ctrl),
        .rd_a        (rd_a),
        .rd_b        (rd_b),
        .dmem_rdata  (dmem_rsp.rdata),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .wb_data     (wb_data)
    );

    // Data memory request
    assign dmem_req.valid = dmem_valid;
    assign dmem_req.store = ctrl.mem_store;
    assign dmem_req.addr  = mem_addr;
    assign dmem_req.wdata = mem_wdata;

endmodule

//--- execute_stage.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module execute_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             operand_en,
    input  logic             result_en,
    input  logic             load_en,
    input  cpu_pkg::ctrl_t   ctrl,
    input  logic [`XLEN-1:0] rd_a,
    input  logic [`XLEN-1:0] rd_b,
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic             jump_taken,
    output logic [`XLEN-1:0] jump_target,
    output logic [`XLEN-1:0] mem_addr,
    output logic [`XLEN-1:0] mem_wdata,
    output logic [`XLEN-1:0] wb_data
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] result_q;
    logic [`XLEN-1:0] load_q;
    logic             cond_met;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_a     <= '0;
            op_b     <= '0;
            result_q <= '0;
        end else begin
            if (operand_en) begin
                op_a <= rd_a;
                op_b <= rd_b;
            end
            if (result_en) begin
                result_q <= alu_out;
            end
        end
    end

    // Load data is captured on the credit pulse
    always_ff @(posedge clk) begin
        if (load_en) begin
            load_q <= dmem_rdata;
        end
    end

    assign alu_b = ctrl.use_imm ? ctrl.imm : op_b;

    always_comb begin
        case (ctrl.alu_op)
            ADD:     alu_out = op_a + alu_b;
            SUB:     alu_out = op_a - alu_b;
            AND:     alu_out = op_a & alu_b;
            OR:      alu_out = op_a | alu_b;
            XOR:     alu_out = op_a ^ alu_b;
            SHL:     alu_out = op_a << alu_b[3:0];
            SHR:     alu_out = op_a >> alu_b[3:0];
            SLT:     alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            default: alu_out = '0;
        endcase
    end

    // Condition tested on operand A
    always_comb begin
        case (ctrl.jump_cond)
            ALWAYS:  cond_met = 1'b1;
            ZERO:    cond_met = (op_a == '0);
            NONZERO: cond_met = (op_a != '0);
            NEG:     cond_met = op_a[`XLEN-1];
            default: cond_met = 1'b0;
        endcase
    end

    assign jump_taken  = ctrl.is_jump && cond_met;
    assign jump_target = op_b;
    assign mem_addr    = result_q;
    assign mem_wdata   = op_b;
    assign wb_data     = ctrl.load_to_reg ? load_q : result_q;

endmodule

//--- register_file.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module register_file (
    input  logic             clk,
    input  logic             rst,
    input  logic             rf_write,
    input  cpu_pkg::ctrl_t   ctrl,
    input  logic [`XLEN-1:0] wb_data,
    output logic [`XLEN-1:0] rd_a,
    output logic [`XLEN-1:0] rd_b
);
    import cpu_pkg::*;

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write) begin
            regs[ctrl.dst] <= wb_data;
        end
    end

    // Reads follow the decoded addresses with no delay
    assign rd_a = regs[ctrl.rs1];
    assign rd_b = regs[ctrl.rb];

    // Write strobe comes from the sequencer, address from the decoder
    a_known_write_addr: assert property (
        @(posedge clk) disable iff (rst) rf_write |-> !$isunknown(ctrl.dst)
    ) else $error("register write with unknown address");

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module instr_decoder (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_en,
    input  cpu_pkg::instr_t instr_in,
    output cpu_pkg::ctrl_t  ctrl
);
    import cpu_pkg::*;

    instr_t instr_q;

    // Instruction register, loaded once per instruction
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            instr_q <= '0;
        end else if (fetch_en) begin
            instr_q <= instr_in;
        end
    end

    always_comb begin
        ctrl = '0;
        ctrl.alu_op    = alu_op_e'(instr_q.r.op);
        ctrl.jump_cond = jump_cond_e'(instr_q.r.op);
        ctrl.dst       = instr_q.r.dst;
        ctrl.rs1       = instr_q.r.rs1;
        ctrl.rb        = instr_q.r.rs2;
        ctrl.imm       = {{(`XLEN-`IMM_W){instr_q.i.imm[`IMM_W-1]}}, instr_q.i.imm};
        case (instr_q.r.cls)
            ALU_REG: begin
                ctrl.reg_write = 1'b1;
            end
            ALU_IMM: begin
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            MEM: begin
                // Address is rs1 plus immediate, store data comes from dst
                ctrl.alu_op      = ADD;
                ctrl.use_imm     = 1'b1;
                ctrl.rb          = instr_q.r.dst;
                ctrl.load_to_reg = (instr_q.r.op == 3'b000);
                ctrl.mem_store   = (instr_q.r.op == 3'b001);
                ctrl.mem_access  = ctrl.load_to_reg || ctrl.mem_store;
                ctrl.reg_write   = ctrl.load_to_reg;
            end
            JUMP: begin
                ctrl.is_jump = 1'b1;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- program_counter.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module program_counter (
    input  logic             clk,
    input  logic             rst,
    input  logic             pc_update,
    input  logic             jump_taken,
    input  logic [`XLEN-1:0] jump_target,
    output logic [`XLEN-1:0] pc
);

    logic [`XLEN-1:0] pc_next;

    // Wraps naturally at the word width
    always_comb begin
        if (jump_taken) begin
            pc_next = jump_target;
        end else begin
            pc_next = pc + `XLEN'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_update) begin
            pc <= pc_next;
        end
    end

endmodule

//--- stage_sequencer.sv
`timescale 1ns/1ps

module stage_sequencer (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::ctrl_t ctrl,
    input  logic           dmem_credit,
    output logic           dmem_valid,
    output logic           fetch_en,
    output logic           operand_en,
    output logic           result_en,
    output logic           load_en,
    output logic           rf_write,
    output logic           pc_update
);
    import cpu_pkg::*;

    stage_e state;
    stage_e state_next;

    // Single data-memory credit held from reset
    logic credit;

    always_comb begin
        state_next = state;
        case (state)
            FETCH:     state_next = DECODE;
            DECODE:    state_next = EXECUTE;
            EXECUTE:   state_next = ctrl.mem_access ? MEM_ISSUE : WRITEBACK;
            MEM_ISSUE: state_next = credit ? MEM_WAIT : MEM_ISSUE;
            MEM_WAIT:  state_next = dmem_credit ? WRITEBACK : MEM_WAIT;
            WRITEBACK: state_next = FETCH;
            default:   state_next = FETCH;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= FETCH;
        end else begin
            state <= state_next;
        end
    end

    // Spent by the request and returned by the pulse
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit <= 1'b1;
        end else if (dmem_valid) begin
            credit <= 1'b0;
        end else if (dmem_credit) begin
            credit <= 1'b1;
        end
    end

    assign dmem_valid = (state == MEM_ISSUE) && credit;
    assign fetch_en   = (state == FETCH);
    assign operand_en = (state == DECODE);
    assign result_en  = (state == EXECUTE);
    assign load_en    = (state == MEM_WAIT) && dmem_credit;
    assign rf_write   = (state == WRITEBACK) && ctrl.reg_write;
    assign pc_update  = (state == WRITEBACK);

    // The request stage is only reached while the credit is back
    a_valid_with_credit: assert property (
        @(posedge clk) disable iff (rst) (state == MEM_ISSUE) |-> credit
    ) else $error("request stage reached without a credit");

    // Memory may only hand back a credit that is outstanding
    a_no_extra_credit: assert property (
        @(posedge clk) disable iff (rst) dmem_credit |-> !credit
    ) else $error("credit returned while already held");

endmodule

//--- cpu_pkg.sv
`include "cpu_settings.svh"

package cpu_pkg;

    // Instruction class in bits 15:14
    typedef enum logic [1:0] {
        ALU_REG = 2'b00,
        ALU_IMM = 2'b01,
        MEM     = 2'b10,
        JUMP    = 2'b11
    } instr_class_e;

    // ALU operation in bits 13:11
    typedef enum logic [2:0] {
        ADD = 3'b000,
        SUB = 3'b001,
        AND = 3'b010,
        OR  = 3'b011,
        XOR = 3'b100,
        SHL = 3'b101,
        SHR = 3'b110,
        SLT = 3'b111
    } alu_op_e;

    // Jump condition, also bits 13:11; unnamed codes never jump
    typedef enum logic [2:0] {
        ALWAYS  = 3'b000,
        ZERO    = 3'b001,
        NONZERO = 3'b010,
        NEG     = 3'b011
    } jump_cond_e;

    // Register form
    typedef struct packed {
        instr_class_e            cls;
        logic [2:0]              op;
        logic [`REG_ADDR_W-1:0]  dst;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rs2;
        logic [1:0]              pad;
    } instr_r_t;

    // Immediate form
    typedef struct packed {
        instr_class_e            cls;
        logic [2:0]              op;
        logic [`REG_ADDR_W-1:0]  dst;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`IMM_W-1:0]       imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_t;

    // Decoded control word
    typedef struct packed {
        alu_op_e                 alu_op;
        jump_cond_e              jump_cond;
        logic [`REG_ADDR_W-1:0]  dst;
        logic [`REG_ADDR_W-1:0]  rs1;
        logic [`REG_ADDR_W-1:0]  rb;
        logic [`XLEN-1:0]        imm;
        logic                    use_imm;
        logic                    reg_write;
        logic                    mem_access;
        logic                    mem_store;
        logic                    is_jump;
        logic                    load_to_reg;
    } ctrl_t;

    typedef struct packed {
        logic             valid;
        logic             store;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic             credit;
        logic [`XLEN-1:0] rdata;
    } dmem_rsp_t;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEM_ISSUE = 3'd3,
        MEM_WAIT  = 3'd4,
        WRITEBACK = 3'd5
    } stage_e;

endpackage

//--- cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data path word width
`define XLEN 16

// General register count and select width
`define REG_COUNT 8
`define REG_ADDR_W 3

// Immediate field of the i view
`define IMM_W 5

`endif
